//--- logic/uart_pkg.sv
package uart_pkg;

    ////////////////////////////////////////////////////////////////////
    // widths and payload types.
    ////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [7:0]        byte_t;
    // bit period in clock cycles minus one.
    typedef logic [15:0]       baud_t;

    ////////////////////////////////////////////////////////////////////
    // address map.
    ////////////////////////////////////////////////////////////////////

    localparam addr_t UART_BASE  = 32'h2000_0000;
    localparam addr_t UART_MASK  = 32'h0000_000F;

    localparam addr_t REG_CTRL   = 32'h0000_0000;
    localparam addr_t REG_STATUS = 32'h0000_0004;
    localparam addr_t REG_RDATA  = 32'h0000_0008;
    localparam addr_t REG_WDATA  = 32'h0000_000C;

    // control register fields.
    localparam int CTRL_TX_EN    = 0;
    localparam int CTRL_RX_EN    = 1;
    localparam int CTRL_BAUD_LSB = 16;

    // status register flags.
    localparam int ST_TX_FULL  = 0;
    localparam int ST_TX_EMPTY = 1;
    localparam int ST_RX_FULL  = 2;
    localparam int ST_RX_EMPTY = 3;

    localparam int TX_DEPTH = 16;
    localparam int RX_DEPTH = 32;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
    } bus_rsp_t;

endpackage

//--- logic/uart_fifo.sv
module uart_fifo import uart_pkg::*; #(
    parameter int DEPTH = TX_DEPTH
) (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  byte_t data_i,
    input  logic  push_i,
    input  logic  pop_i,
    output byte_t data_o,
    output logic  full_o,
    output logic  empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    byte_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // overflow and underflow requests are dropped.
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- logic/uart_tx.sv
module uart_tx import uart_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  en_i,
    input  baud_t baud_i,
    input  byte_t data_i,
    input  logic  empty_i,
    output logic  pop_o,
    output logic  tx_o
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

    state_e     state_q;
    baud_t      cnt_q;
    logic [2:0] bit_q;
    byte_t      shift_q;
    logic       bit_done;

    // a new frame starts only from idle, so a running frame always completes.
    assign pop_o    = (state_q == IDLE) && en_i && !empty_i;
    assign bit_done = (cnt_q >= baud_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else begin
            if (state_q != IDLE) begin
                cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
            end
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (pop_o) begin
                        state_q <= START;
                    end
                end
                START: begin
                    if (bit_done) begin
                        state_q <= DATA;
                        bit_q   <= '0;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    // lsb goes out first.
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shift_q <= data_i;
        end else if (state_q == DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state_q)
            START:   tx_o = 1'b0;
            DATA:    tx_o = shift_q[0];
            default: tx_o = 1'b1;
        endcase
    end

endmodule

//--- logic/uart_rx.sv
module uart_rx import uart_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  en_i,
    input  baud_t baud_i,
    input  logic  rx_i,
    output byte_t data_o,
    output logic  push_o
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

    state_e     state_q;
    baud_t      cnt_q;
    baud_t      half;
    logic [2:0] bit_q;
    byte_t      shift_q;
    logic       rx_meta_q;
    logic       rx_sync_q;
    logic       rx_prev_q;
    logic       bit_done;

    assign half     = baud_i >> 1;
    assign bit_done = (cnt_q >= baud_i);
    assign data_o   = shift_q;

    // line idles high.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            push_o  <= 1'b0;
        end else begin
            push_o <= 1'b0;
            cnt_q  <= cnt_q + 1'b1;
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (en_i && rx_prev_q && !rx_sync_q) begin
                        state_q <= START;
                    end
                end
                START: begin
                    // middle of start bit; a high line here was a glitch.
                    if (cnt_q >= half) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rx_sync_q ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        push_o  <= rx_sync_q;
                        state_q <= IDLE;
                    end
                end
            endcase
            if (!en_i) begin
                state_q <= IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DATA && bit_done) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

endmodule

//--- logic/uart_regs.sv
module uart_regs import uart_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  bus_req_t req_i,
    input  logic     valid_i,
    output logic     ready_o,

    output bus_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,

    input  logic     tx_full_i,
    input  logic     tx_empty_i,
    input  logic     rx_full_i,
    input  logic     rx_empty_i,

    output logic     tx_push_o,
    output byte_t    tx_byte_o,
    input  byte_t    rx_byte_i,
    output logic     rx_pop_o,

    output logic     tx_en_o,
    output logic     rx_en_o,
    output baud_t    baud_o
);

    typedef enum logic {IDLE, RESP} state_e;

    state_e   state_q;
    word_t    ctrl_q;
    bus_rsp_t rsp_q;
    word_t    status;
    word_t    rd_data;
    addr_t    offset;
    logic     in_win;
    logic     accept;
    logic     wr_acc;
    logic     rd_acc;

    ////////////////////////////////////////////////////////////////////
    // request decode.
    ////////////////////////////////////////////////////////////////////

    assign in_win = ((req_i.addr & ~UART_MASK) == UART_BASE);
    assign offset = req_i.addr & UART_MASK;

    // busy while a read response waits.
    assign ready_o = (state_q == IDLE);
    assign accept  = valid_i && ready_o;
    assign wr_acc  = accept && req_i.we && in_win;
    assign rd_acc  = accept && !req_i.we;

    assign tx_push_o = wr_acc && (offset == REG_WDATA);
    assign tx_byte_o = req_i.wdata[7:0];
    assign rx_pop_o  = rd_acc && in_win && (offset == REG_RDATA) && !rx_empty_i;

    always_comb begin
        status              = '0;
        status[ST_TX_FULL]  = tx_full_i;
        status[ST_TX_EMPTY] = tx_empty_i;
        status[ST_RX_FULL]  = rx_full_i;
        status[ST_RX_EMPTY] = rx_empty_i;
    end

    // outside the window everything reads as zero.
    always_comb begin
        rd_data = '0;
        if (in_win) begin
            case (offset)
                REG_CTRL:   rd_data = ctrl_q;
                REG_STATUS: rd_data = status;
                REG_RDATA:  rd_data = rx_empty_i ? '0 : word_t'(rx_byte_i);
                default:    rd_data = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // control register and response FSM.
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            ctrl_q  <= '0;
        end else begin
            if (wr_acc && offset == REG_CTRL) begin
                ctrl_q <= req_i.wdata;
            end
            case (state_q)
                IDLE: begin
                    if (rd_acc) begin
                        state_q <= RESP;
                    end
                end
                default: begin
                    if (rsp_ready_i) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_acc) begin
            rsp_q.rdata <= rd_data;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = (state_q == RESP);

    assign tx_en_o = ctrl_q[CTRL_TX_EN];
    assign rx_en_o = ctrl_q[CTRL_RX_EN];
    assign baud_o  = ctrl_q[CTRL_BAUD_LSB +: $bits(baud_t)];

endmodule

//--- logic/uart_top.sv
module uart_top import uart_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  bus_req_t bus_req_i,
    input  logic     bus_valid_i,
    output logic     bus_ready_o,

    output bus_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,

    input  logic     rx_i,
    output logic     tx_o
);

    logic  tx_push;
    logic  tx_pop;
    logic  tx_full;
    logic  tx_empty;
    byte_t tx_byte;
    byte_t tx_head;

    logic  rx_push;
    logic  rx_pop;
    logic  rx_full;
    logic  rx_empty;
    byte_t rx_byte;
    byte_t rx_head;

    logic  tx_en;
    logic  rx_en;
    baud_t baud;

    ////////////////////////////////////////////////////////////////////
    // register front end.
    ////////////////////////////////////////////////////////////////////

    uart_regs regs_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (bus_req_i),
        .valid_i     (bus_valid_i),
        .ready_o     (bus_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .tx_full_i   (tx_full),
        .tx_empty_i  (tx_empty),
        .rx_full_i   (rx_full),
        .rx_empty_i  (rx_empty),
        .tx_push_o   (tx_push),
        .tx_byte_o   (tx_byte),
        .rx_byte_i   (rx_head),
        .rx_pop_o    (rx_pop),
        .tx_en_o     (tx_en),
        .rx_en_o     (rx_en),
        .baud_o      (baud)
    );

    ////////////////////////////////////////////////////////////////////
    // transmit path.
    ////////////////////////////////////////////////////////////////////

    uart_fifo #(.DEPTH(TX_DEPTH)) tx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .data_i  (tx_byte),
        .push_i  (tx_push),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    uart_tx tx_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (tx_en),
        .baud_i  (baud),
        .data_i  (tx_head),
        .empty_i (tx_empty),
        .pop_o   (tx_pop),
        .tx_o    (tx_o)
    );

    ////////////////////////////////////////////////////////////////////
    // receive path.
    ////////////////////////////////////////////////////////////////////

    uart_rx rx_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (rx_en),
        .baud_i (baud),
        .rx_i   (rx_i),
        .data_o (rx_byte),
        .push_o (rx_push)
    );

    uart_fifo #(.DEPTH(RX_DEPTH)) rx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .data_i  (rx_byte),
        .push_i  (rx_push),
        .pop_i   (rx_pop),
        .data_o  (rx_head),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

endmodule

//--- tests/uart_tb.sv
module uart_tb import uart_pkg::*; ();

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RX, OP_POLL, OP_HOLD, OP_WAIT} op_e;

    typedef struct packed {
        op_e   op;
        addr_t addr;
        word_t value;
        word_t exp_data;
    } step_t;

    localparam int BUS_TIMEOUT = 50;
    localparam int POLL_LIMIT  = 200;
    localparam int FRAME_WAIT  = 100;

    localparam addr_t A_CTRL   = UART_BASE | REG_CTRL;
    localparam addr_t A_STATUS = UART_BASE | REG_STATUS;
    localparam addr_t A_RDATA  = UART_BASE | REG_RDATA;
    localparam addr_t A_WDATA  = UART_BASE | REG_WDATA;

    localparam word_t BAUD_7   = word_t'(7) << CTRL_BAUD_LSB;
    localparam word_t TX_ON    = word_t'(1) << CTRL_TX_EN;
    localparam word_t RX_ON    = word_t'(1) << CTRL_RX_EN;
    localparam word_t TX_FULL  = word_t'(1) << ST_TX_FULL;
    localparam word_t TX_EMPTY = word_t'(1) << ST_TX_EMPTY;
    localparam word_t RX_EMPTY = word_t'(1) << ST_RX_EMPTY;

    logic        clk = 1'b0;
    logic        rstn;
    bus_req_t    bus_req;
    logic        bus_valid;
    logic        bus_ready;
    bus_rsp_t    rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    logic        line;
    logic [31:0] lfsr_q = 32'hff0242a4;
    int          errors = 0;
    int          timeouts = 0;
    step_t       steps [$];

    always #2 clk = ~clk;

    // external loopback.
    uart_top uart_top_inst (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .bus_req_i   (bus_req),
        .bus_valid_i (bus_valid),
        .bus_ready_o (bus_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rx_i        (line),
        .tx_o        (line)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus access, entered and left just after a falling edge.
    //////////////////////////////////////////////////////////////////////

    task automatic bus_xfer(input addr_t addr, input word_t wdata, input logic we);
        int cnt;
        bus_req   = '{addr: addr, wdata: wdata, we: we};
        bus_valid = 1'b1;
        cnt = 0;
        while (!bus_ready && cnt < BUS_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!bus_ready) begin
            timeouts++;
            $display("timeout at %0t: bus never raised ready for %h", $time, addr);
        end else begin
            @(negedge clk);
        end
        bus_valid = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, output word_t data);
        int cnt;
        int hold;
        data = '0;
        bus_xfer(addr, '0, 1'b0);
        cnt = 0;
        while (timeouts == 0 && !rsp_valid && cnt < BUS_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (timeouts == 0 && !rsp_valid) begin
            timeouts++;
            $display("timeout at %0t: no read response for %h", $time, addr);
        end
        if (timeouts == 0) begin
            data = rsp.rdata;
            take_bits(2, hold);
            // stall the response 1 to 4 cycles.
            repeat (hold + 1) begin
                @(negedge clk);
                if (rsp.rdata !== data || bus_ready !== 1'b0 || rsp_valid !== 1'b1) begin
                    errors++;
                    $display("[ERROR] %0t: response to %h not held under back-pressure",
                             $time, addr);
                end
            end
            rsp_ready = 1'b1;
            @(negedge clk);
            rsp_ready = 1'b0;
        end
    endtask

    task automatic poll_status(input word_t mask, input word_t exp_data);
        word_t d;
        d = '0;
        for (int n = 0; n < POLL_LIMIT; n++) begin
            bus_read(A_STATUS, d);
            if (timeouts != 0 || (d & mask) == exp_data) begin
                break;
            end
        end
        if (timeouts == 0 && (d & mask) != exp_data) begin
            timeouts++;
            $display("timeout at %0t: STATUS never reached %h under mask %h",
                     $time, exp_data, mask);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table.
    //////////////////////////////////////////////////////////////////////

    task automatic add_step(input op_e op, input addr_t addr, input word_t value,
                            input word_t exp_data);
        steps.push_back('{op: op, addr: addr, value: value, exp_data: exp_data});
    endtask

    task automatic build_table();
        byte_t loop_bytes [5] = '{8'h55, 8'hA3, 8'h01, 8'hFE, 8'h7C};
        // reset state.
        add_step(OP_RD, A_STATUS, '0, TX_EMPTY | RX_EMPTY);
        add_step(OP_RD, A_CTRL, '0, '0);
        add_step(OP_HOLD, '0, 8, '0);
        // control register and window decode.
        add_step(OP_WR, A_CTRL, BAUD_7 | TX_ON | RX_ON, '0);
        add_step(OP_RD, A_CTRL, '0, BAUD_7 | TX_ON | RX_ON);
        add_step(OP_RD, 32'h3000_0000, '0, '0);
        add_step(OP_RD, UART_BASE + 32'h10, '0, '0);
        add_step(OP_WR, 32'h1000_0000, 32'hFFFF_FFFF, '0);
        add_step(OP_RD, A_CTRL, '0, BAUD_7 | TX_ON | RX_ON);
        // loopback order.
        foreach (loop_bytes[i]) add_step(OP_WR, A_WDATA, word_t'(loop_bytes[i]), '0);
        foreach (loop_bytes[i]) add_step(OP_RX, A_RDATA, '0, word_t'(loop_bytes[i]));
        add_step(OP_POLL, '0, RX_EMPTY, RX_EMPTY);
        add_step(OP_RD, A_RDATA, '0, '0);
        add_step(OP_RD, A_RDATA, '0, '0);
        // hold the transmitter, overfill by one.
        add_step(OP_WR, A_CTRL, BAUD_7 | RX_ON, '0);
        for (int i = 0; i < 17; i++) add_step(OP_WR, A_WDATA, word_t'(8'h30 + i), '0);
        add_step(OP_RD, A_STATUS, '0, TX_FULL | RX_EMPTY);
        add_step(OP_HOLD, '0, FRAME_WAIT, '0);
        add_step(OP_WR, A_CTRL, BAUD_7 | TX_ON | RX_ON, '0);
        for (int i = 0; i < 16; i++) add_step(OP_RX, A_RDATA, '0, word_t'(8'h30 + i));
        add_step(OP_POLL, '0, TX_EMPTY | RX_EMPTY, TX_EMPTY | RX_EMPTY);
        add_step(OP_WAIT, '0, FRAME_WAIT, '0);
        add_step(OP_RD, A_STATUS, '0, TX_EMPTY | RX_EMPTY);
        // receiver disabled.
        add_step(OP_WR, A_CTRL, BAUD_7 | TX_ON, '0);
        for (int i = 0; i < 3; i++) add_step(OP_WR, A_WDATA, word_t'(8'hC0 + i), '0);
        add_step(OP_POLL, '0, TX_EMPTY, TX_EMPTY);
        add_step(OP_WAIT, '0, FRAME_WAIT, '0);
        add_step(OP_RD, A_STATUS, '0, TX_EMPTY | RX_EMPTY);
    endtask

    task automatic run_step(input step_t s);
        word_t d;
        case (s.op)
            OP_WR: bus_xfer(s.addr, s.value, 1'b1);
            OP_RD, OP_RX: begin
                if (s.op == OP_RX) begin
                    poll_status(RX_EMPTY, '0);
                end
                if (timeouts == 0) begin
                    bus_read(s.addr, d);
                    if (timeouts == 0 && d !== s.exp_data) begin
                        errors++;
                        $display("[ERROR] %0t: read of %h returned %h, expected %h",
                                 $time, s.addr, d, s.exp_data);
                    end
                end
            end
            OP_POLL: poll_status(s.value, s.exp_data);
            OP_HOLD: begin
                repeat (s.value) begin
                    @(negedge clk);
                    if (line !== 1'b1) begin
                        errors++;
                        $display("[ERROR] %0t: tx_o left idle high", $time);
                    end
                end
            end
            default: repeat (s.value) @(negedge clk);
        endcase
    endtask

    initial begin
        rstn      = 1'b0;
        bus_req   = '0;
        bus_valid = 1'b0;
        rsp_ready = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < steps.size() && timeouts == 0; i++) begin
            run_step(steps[i]);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
tests/uart_tb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - logic/uart_pkg.sv
  - logic/uart_fifo.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/uart_regs.sv
  - logic/uart_top.sv
  - target: test
    files:
      - tests/uart_tb.sv
